// File: testbench/cpu_tests.txt
// Word 0 is the program length, then one hex instruction word per program slot
// Then the count of expected output bytes, then those bytes in output order
30
// ALU ops on x1 = 25 and x2 = -100, each followed by OUT
01900093 F9C00113 0000800B 002081B3
0001800B 40208233 0002000B 0020F2B3
0002800B 0020E333 0003000B 0020C3B3
0003800B 0020A433 0004000B 001124B3
0004800B
// SW to words 2 and 3, LW back in swapped order, ADDI to x0
00102423 00702623 00C02503 00802583
0005000B 0005800B 00508013 0000000B
// BEQ and BNE taken and not taken, then a five pass countdown
00208463 0000800B 00108463 0001000B
00109463 0004800B 00209463 0001000B
00500613 0006000B FFF60613 FE061CE3
0006000B
// JAL link, LUI with ADDI and SUB, self-loop at the end
008006EF 0001000B 0006800B 12345737
67870713 0007000B 123467B7 40E78833
0008000B 0000006F
16
// ALU results
19 B5 7D 18 9D 85 00 01
// Loads and x0
85 19 00
// Branch path and countdown
19 01 05 04 03 02 01 00
// Jump link and upper immediates
9C 78 88

// File: sim.f
src/isa_pkg.sv
src/cpu_pkg.sv
src/stage_sequencer.sv
src/fetch_unit.sv
src/decoder.sv
src/register_file.sv
src/execute_unit.sv
src/memory_access.sv
src/cpu_top.sv
testbench/tb_cpu_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_cpu_top \
    -Mdir obj_dir \
    -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_cpu_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0

// File: testbench/tb_cpu_top.sv
`timescale 1ns/10ps

module tb_cpu_top;

    import isa_pkg::*;

    localparam int PROG_ADDR_WIDTH = 8;
    localparam int RAM_ADDR_WIDTH  = 8;
    localparam int DATA_DEPTH      = 1024;
    localparam int POST_CYCLES     = 200;
    localparam int MIN_SPACING     = 5;

    logic                       clk;
    logic                       reset_n;
    logic                       prog_write_enable;
    logic [PROG_ADDR_WIDTH-1:0] prog_write_address;
    instr_t                     prog_write_data;
    logic                       run;
    logic                       out_valid;
    logic [7:0]                 out_data;

    // Length, program words, byte count, expected bytes
    logic [31:0] test_data [DATA_DEPTH];
    int          prog_length;
    int          expected_base;
    int          expected_count;
    int          received_count;
    int          since_pulse;
    int          cycle_count;
    int          cycle_limit;

    cpu_top #(
        .PROG_ADDR_WIDTH(PROG_ADDR_WIDTH),
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_cpu_top (
        .clk, .reset_n,
        .prog_write_enable, .prog_write_address, .prog_write_data,
        .run, .out_valid, .out_data
    );

    always #2 clk = ~clk;

    task automatic check_byte(input logic [7:0] actual, input logic [7:0] expected);
        if (actual !== expected) begin
            $display("mismatch out_data: expected 0x%02h, got 0x%02h (byte %0d)",
                     expected, actual, received_count);
            $display("Some tests failed");
            $fatal(1, "Output byte check failed");
        end
    endtask

    task automatic check_idle(input logic valid);
        if (valid !== 1'b0) begin
            $display("mismatch out_valid: expected 0x0, got 0x%0h at cycle %0d",
                     valid, cycle_count);
            $display("Some tests failed");
            $fatal(1, "Output strobe where none may occur");
        end
    endtask

    task automatic read_tests();
        $readmemh("testbench/cpu_tests.txt", test_data);
        prog_length = test_data[0];
        if (prog_length <= 0 || prog_length > 2**PROG_ADDR_WIDTH) begin
            $display("Some tests failed");
            $fatal(1, "Test data file holds no usable program length");
        end else begin
            expected_base  = prog_length + 2;
            expected_count = test_data[prog_length + 1];
            // Load cycles plus five cycles per instruction with room for loops
            cycle_limit    = 3 * prog_length + 5 * 16 * prog_length;
        end
    endtask

    task automatic load_program();
        for (int n = 0; n < prog_length; n++) begin
            @(posedge clk);
            prog_write_enable  <= 1'b1;
            prog_write_address <= PROG_ADDR_WIDTH'(n);
            prog_write_data    <= instr_t'(test_data[n + 1]);
        end
        @(posedge clk);
        prog_write_enable <= 1'b0;
    endtask

    // Output monitor sampled mid-cycle
    always @(negedge clk) begin
        if (since_pulse < MIN_SPACING) begin
            since_pulse = since_pulse + 1;
        end
        if (!reset_n || !run || since_pulse < MIN_SPACING) begin
            check_idle(out_valid);
        end else if (out_valid) begin
            if (received_count >= expected_count) begin
                $display("Some tests failed");
                $fatal(1, "Extra output byte 0x%02h after the last expected byte", out_data);
            end else begin
                check_byte(out_data, test_data[expected_base + received_count][7:0]);
                received_count = received_count + 1;
                since_pulse    = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Some tests failed");
            if (received_count < expected_count) begin
                $fatal(1, "Output stopped early, %0d of %0d bytes received",
                       received_count, expected_count);
            end else begin
                $fatal(1, "Run did not finish within %0d cycles", cycle_limit);
            end
        end
    end

    initial begin
        clk                = 1'b0;
        reset_n            = 1'b0;
        run                = 1'b0;
        prog_write_enable  = 1'b0;
        prog_write_address = '0;
        prog_write_data    = '0;
        received_count     = 0;
        expected_count     = 0;
        since_pulse        = MIN_SPACING;
        cycle_count        = 0;
        cycle_limit        = 0;

        read_tests();

        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        load_program();
        // Core must stay quiet with run low
        repeat (5) @(posedge clk);
        run <= 1'b1;

        wait (received_count == expected_count);
        repeat (POST_CYCLES) @(posedge clk);

        $display("All tests passed");
        $finish;
    end

endmodule

// File: src/cpu_top.sv
`timescale 1ns/10ps

module cpu_top #(
    parameter int PROG_ADDR_WIDTH = 8,
    parameter int RAM_ADDR_WIDTH  = 8
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       prog_write_enable,
    input  logic [PROG_ADDR_WIDTH-1:0] prog_write_address,
    input  isa_pkg::instr_t            prog_write_data,
    input  logic                       run,
    output logic                       out_valid,
    output logic [7:0]                 out_data
);

    import isa_pkg::*;
    import cpu_pkg::*;

    logic fetch_enable;
    logic decode_enable;
    logic execute_enable;
    logic memory_enable;
    logic writeback_enable;

    instr_t          instruction;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;

    logic [REG_ADDR_WIDTH-1:0] rs1_address;
    logic [REG_ADDR_WIDTH-1:0] rs2_address;
    logic [REG_ADDR_WIDTH-1:0] rd_address;
    logic [XLEN-1:0]           imm;
    logic [ALU_OP_WIDTH-1:0]   alu_op;
    logic [OPA_SEL_WIDTH-1:0]  opa_sel;
    logic [OPB_SEL_WIDTH-1:0]  opb_sel;
    logic [NEXT_PC_WIDTH-1:0]  next_pc_sel;
    logic                      wb_sel;
    logic                      reg_write;
    logic                      ram_write;
    logic                      out_write;

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    logic [XLEN-1:0] alu_result;
    logic            result_is_zero;
    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] rs1_value;
    logic [XLEN-1:0] rs2_value;
    logic [XLEN-1:0] pc_plus_four;

    logic                      reg_write_enable;
    logic [REG_ADDR_WIDTH-1:0] reg_write_address;
    logic [XLEN-1:0]           reg_write_data;

    stage_sequencer u_stage_sequencer (
        .clk, .reset_n, .run,
        .fetch_enable, .decode_enable, .execute_enable, .memory_enable, .writeback_enable
    );

    fetch_unit #(
        .PROG_ADDR_WIDTH(PROG_ADDR_WIDTH)
    ) u_fetch_unit (
        .clk, .reset_n, .fetch_enable, .writeback_enable, .next_pc,
        .prog_write_enable, .prog_write_address, .prog_write_data,
        .instruction, .pc
    );

    decoder u_decoder (
        .clk, .reset_n, .decode_enable, .instruction,
        .rs1_address, .rs2_address, .rd_address, .imm,
        .alu_op, .opa_sel, .opb_sel, .next_pc_sel, .wb_sel,
        .reg_write, .ram_write, .out_write
    );

    register_file u_register_file (
        .clk, .reset_n, .rs1_address, .rs2_address,
        .write_enable  (reg_write_enable),
        .write_address (reg_write_address),
        .write_data    (reg_write_data),
        .rs1_data, .rs2_data
    );

    execute_unit u_execute_unit (
        .clk, .reset_n, .execute_enable, .pc, .rs1_data, .rs2_data, .imm,
        .alu_op, .opa_sel, .opb_sel,
        .alu_result, .result_is_zero, .branch_target, .rs1_value, .rs2_value, .pc_plus_four
    );

    memory_access #(
        .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
    ) u_memory_access (
        .clk, .reset_n, .memory_enable, .writeback_enable,
        .alu_result, .result_is_zero, .branch_target, .rs1_value, .rs2_value, .pc_plus_four,
        .rd_address, .next_pc_sel, .wb_sel, .reg_write, .ram_write, .out_write,
        .next_pc, .reg_write_enable, .reg_write_address, .reg_write_data,
        .out_valid, .out_data
    );

endmodule

// File: src/memory_access.sv
`timescale 1ns/10ps

module memory_access #(
    parameter int RAM_ADDR_WIDTH = 8
) (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                memory_enable,
    input  logic                                writeback_enable,
    input  logic [cpu_pkg::XLEN-1:0]            alu_result,
    input  logic                                result_is_zero,
    input  logic [cpu_pkg::XLEN-1:0]            branch_target,
    input  logic [cpu_pkg::XLEN-1:0]            rs1_value,
    input  logic [cpu_pkg::XLEN-1:0]            rs2_value,
    input  logic [cpu_pkg::XLEN-1:0]            pc_plus_four,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  rd_address,
    input  logic [cpu_pkg::NEXT_PC_WIDTH-1:0]   next_pc_sel,
    input  logic                                wb_sel,
    input  logic                                reg_write,
    input  logic                                ram_write,
    input  logic                                out_write,
    output logic [cpu_pkg::XLEN-1:0]            next_pc,
    output logic                                reg_write_enable,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  reg_write_address,
    output logic [cpu_pkg::XLEN-1:0]            reg_write_data,
    output logic                                out_valid,
    output logic [7:0]                          out_data
);

    import cpu_pkg::*;

    logic [XLEN-1:0]           ram [2**RAM_ADDR_WIDTH];
    logic [RAM_ADDR_WIDTH-1:0] ram_index;
    logic [XLEN-1:0]           ram_read_data;

    assign ram_index = alu_result[RAM_ADDR_WIDTH+1:2];

    always_ff @(posedge clk) begin
        if (memory_enable && ram_write) begin
            ram[ram_index] <= rs2_value;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ram_read_data <= '0;
        end else if (memory_enable) begin
            ram_read_data <= ram[ram_index];
        end
    end

    always_comb begin
        case (next_pc_sel)
            NEXT_PC_IF_ZERO:    next_pc = result_is_zero ? branch_target : pc_plus_four;
            NEXT_PC_IF_NONZERO: next_pc = result_is_zero ? pc_plus_four : branch_target;
            NEXT_PC_ALWAYS:     next_pc = branch_target;
            default:            next_pc = pc_plus_four;
        endcase
    end

    // OUT leaves as a single-cycle strobe in the memory cycle
    assign out_valid = memory_enable & out_write;
    assign out_data  = rs1_value[7:0];

    assign reg_write_enable  = writeback_enable & reg_write;
    assign reg_write_address = rd_address;
    assign reg_write_data    = (wb_sel == WB_SEL_RAM) ? ram_read_data : alu_result;

endmodule

// File: src/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               execute_enable,
    input  logic [cpu_pkg::XLEN-1:0]           pc,
    input  logic [cpu_pkg::XLEN-1:0]           rs1_data,
    input  logic [cpu_pkg::XLEN-1:0]           rs2_data,
    input  logic [cpu_pkg::XLEN-1:0]           imm,
    input  logic [cpu_pkg::ALU_OP_WIDTH-1:0]   alu_op,
    input  logic [cpu_pkg::OPA_SEL_WIDTH-1:0]  opa_sel,
    input  logic [cpu_pkg::OPB_SEL_WIDTH-1:0]  opb_sel,
    output logic [cpu_pkg::XLEN-1:0]           alu_result,
    output logic                               result_is_zero,
    output logic [cpu_pkg::XLEN-1:0]           branch_target,
    output logic [cpu_pkg::XLEN-1:0]           rs1_value,
    output logic [cpu_pkg::XLEN-1:0]           rs2_value,
    output logic [cpu_pkg::XLEN-1:0]           pc_plus_four
);

    import cpu_pkg::*;

    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_out;

    assign operand_a = (opa_sel == OPA_PC) ? pc : rs1_data;

    always_comb begin
        case (opb_sel)
            OPB_RS2:  operand_b = rs2_data;
            OPB_IMM:  operand_b = imm;
            OPB_FOUR: operand_b = XLEN'(4);
            default:  operand_b = '0;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_out = operand_a + operand_b;
            ALU_SUB:    alu_out = operand_a - operand_b;
            ALU_AND:    alu_out = operand_a & operand_b;
            ALU_OR:     alu_out = operand_a | operand_b;
            ALU_XOR:    alu_out = operand_a ^ operand_b;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            ALU_PASS_B: alu_out = operand_b;
            default:    alu_out = '0;
        endcase
    end

    // Branch condition flag feeds next-PC control
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            result_is_zero <= 1'b0;
        end else if (execute_enable) begin
            result_is_zero <= (alu_out == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (execute_enable) begin
            alu_result    <= alu_out;
            branch_target <= pc + imm;
            rs1_value     <= rs1_data;
            rs2_value     <= rs2_data;
            pc_plus_four  <= pc + XLEN'(4);
        end
    end

endmodule

// File: src/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  rs1_address,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  rs2_address,
    input  logic                                write_enable,
    input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  write_address,
    input  logic [cpu_pkg::XLEN-1:0]            write_data,
    output logic [cpu_pkg::XLEN-1:0]            rs1_data,
    output logic [cpu_pkg::XLEN-1:0]            rs2_data
);

    import cpu_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int n = 0; n < 2**REG_ADDR_WIDTH; n++) begin
                regs[n] <= '0;
            end
        end else if (write_enable && (write_address != '0)) begin
            regs[write_address] <= write_data;
        end
    end

    // x0 hardwired
    assign rs1_data = (rs1_address == '0) ? '0 : regs[rs1_address];
    assign rs2_data = (rs2_address == '0) ? '0 : regs[rs2_address];

endmodule

// File: src/decoder.sv
`timescale 1ns/10ps

module decoder (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                decode_enable,
    input  isa_pkg::instr_t                     instruction,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  rs1_address,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  rs2_address,
    output logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  rd_address,
    output logic [cpu_pkg::XLEN-1:0]            imm,
    output logic [cpu_pkg::ALU_OP_WIDTH-1:0]    alu_op,
    output logic [cpu_pkg::OPA_SEL_WIDTH-1:0]   opa_sel,
    output logic [cpu_pkg::OPB_SEL_WIDTH-1:0]   opb_sel,
    output logic [cpu_pkg::NEXT_PC_WIDTH-1:0]   next_pc_sel,
    output logic                                wb_sel,
    output logic                                reg_write,
    output logic                                ram_write,
    output logic                                out_write
);

    import isa_pkg::*;
    import cpu_pkg::*;

    logic [XLEN-1:0]          imm_d;
    logic [ALU_OP_WIDTH-1:0]  alu_op_d;
    logic [OPA_SEL_WIDTH-1:0] opa_sel_d;
    logic [OPB_SEL_WIDTH-1:0] opb_sel_d;
    logic [NEXT_PC_WIDTH-1:0] next_pc_sel_d;
    logic                     wb_sel_d;
    logic                     reg_write_d;
    logic                     ram_write_d;
    logic                     out_write_d;

    // Register reads happen during the decode cycle
    assign rs1_address = instruction.r.rs1;
    assign rs2_address = instruction.r.rs2;

    always_comb begin
        imm_d         = '0;
        alu_op_d      = ALU_ADD;
        opa_sel_d     = OPA_RS1;
        opb_sel_d     = OPB_RS2;
        next_pc_sel_d = NEXT_PC_SEQ;
        wb_sel_d      = WB_SEL_ALU;
        reg_write_d   = 1'b0;
        ram_write_d   = 1'b0;
        out_write_d   = 1'b0;
        case (instruction.r.opcode)
            OPC_OP: begin
                reg_write_d = 1'b1;
                case (instruction.r.funct3)
                    F3_ADD_SUB: alu_op_d = (instruction.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:     alu_op_d = ALU_SLT;
                    F3_XOR:     alu_op_d = ALU_XOR;
                    F3_OR:      alu_op_d = ALU_OR;
                    F3_AND:     alu_op_d = ALU_AND;
                    default:    reg_write_d = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                imm_d       = {{20{instruction.i.imm_11_0[11]}}, instruction.i.imm_11_0};
                opb_sel_d   = OPB_IMM;
                reg_write_d = (instruction.i.funct3 == F3_ADD_SUB);
            end
            OPC_LOAD: begin
                imm_d       = {{20{instruction.i.imm_11_0[11]}}, instruction.i.imm_11_0};
                opb_sel_d   = OPB_IMM;
                wb_sel_d    = WB_SEL_RAM;
                reg_write_d = 1'b1;
            end
            OPC_STORE: begin
                imm_d       = {{20{instruction.s.imm_11_5[6]}}, instruction.s.imm_11_5,
                               instruction.s.imm_4_0};
                opb_sel_d   = OPB_IMM;
                ram_write_d = 1'b1;
            end
            OPC_BRANCH: begin
                imm_d    = {{19{instruction.b.imm_12}}, instruction.b.imm_12,
                            instruction.b.imm_11, instruction.b.imm_10_5,
                            instruction.b.imm_4_1, 1'b0};
                alu_op_d = ALU_SUB;
                if (instruction.b.funct3 == F3_BEQ) begin
                    next_pc_sel_d = NEXT_PC_IF_ZERO;
                end else if (instruction.b.funct3 == F3_BNE) begin
                    next_pc_sel_d = NEXT_PC_IF_NONZERO;
                end
            end
            OPC_JAL: begin
                imm_d         = {{11{instruction.j.imm_20}}, instruction.j.imm_20,
                                 instruction.j.imm_19_12, instruction.j.imm_11,
                                 instruction.j.imm_10_1, 1'b0};
                // Link value is pc + 4
                opa_sel_d     = OPA_PC;
                opb_sel_d     = OPB_FOUR;
                next_pc_sel_d = NEXT_PC_ALWAYS;
                reg_write_d   = 1'b1;
            end
            OPC_LUI: begin
                imm_d       = {instruction.u.imm_31_12, 12'b0};
                alu_op_d    = ALU_PASS_B;
                opb_sel_d   = OPB_IMM;
                reg_write_d = 1'b1;
            end
            OPC_OUT: out_write_d = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            next_pc_sel <= NEXT_PC_SEQ;
            reg_write   <= 1'b0;
            ram_write   <= 1'b0;
            out_write   <= 1'b0;
        end else if (decode_enable) begin
            next_pc_sel <= next_pc_sel_d;
            reg_write   <= reg_write_d;
            ram_write   <= ram_write_d;
            out_write   <= out_write_d;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_enable) begin
            rd_address <= instruction.r.rd;
            imm        <= imm_d;
            alu_op     <= alu_op_d;
            opa_sel    <= opa_sel_d;
            opb_sel    <= opb_sel_d;
            wb_sel     <= wb_sel_d;
        end
    end

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
    parameter int PROG_ADDR_WIDTH = 8
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         fetch_enable,
    input  logic                         writeback_enable,
    input  logic [cpu_pkg::XLEN-1:0]     next_pc,
    input  logic                         prog_write_enable,
    input  logic [PROG_ADDR_WIDTH-1:0]   prog_write_address,
    input  isa_pkg::instr_t              prog_write_data,
    output isa_pkg::instr_t              instruction,
    output logic [cpu_pkg::XLEN-1:0]     pc
);

    import isa_pkg::*;
    import cpu_pkg::*;

    instr_t         prog_mem [2**PROG_ADDR_WIDTH];
    logic [XLEN-1:0] pc_current;

    always_ff @(posedge clk) begin
        if (prog_write_enable) begin
            prog_mem[prog_write_address] <= prog_write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc_current <= '0;
        end else if (writeback_enable) begin
            pc_current <= next_pc;
        end
    end

    // Word addressed, low two PC bits ignored
    always_ff @(posedge clk) begin
        if (fetch_enable) begin
            instruction <= prog_mem[pc_current[PROG_ADDR_WIDTH+1:2]];
            pc          <= pc_current;
        end
    end

endmodule

// File: src/stage_sequencer.sv
`timescale 1ns/10ps

module stage_sequencer (
    input  logic clk,
    input  logic reset_n,
    input  logic run,
    output logic fetch_enable,
    output logic decode_enable,
    output logic execute_enable,
    output logic memory_enable,
    output logic writeback_enable
);

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_FETCH     = 3'd1;
    localparam logic [2:0] S_DECODE    = 3'd2;
    localparam logic [2:0] S_EXECUTE   = 3'd3;
    localparam logic [2:0] S_MEMORY    = 3'd4;
    localparam logic [2:0] S_WRITEBACK = 3'd5;

    logic [2:0] state;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:      state <= run ? S_FETCH : S_IDLE;
                S_FETCH:     state <= S_DECODE;
                S_DECODE:    state <= S_EXECUTE;
                S_EXECUTE:   state <= S_MEMORY;
                S_MEMORY:    state <= S_WRITEBACK;
                // Instruction in flight always completes before stopping
                S_WRITEBACK: state <= run ? S_FETCH : S_IDLE;
                default:     state <= S_IDLE;
            endcase
        end
    end

    assign fetch_enable     = (state == S_FETCH);
    assign decode_enable    = (state == S_DECODE);
    assign execute_enable   = (state == S_EXECUTE);
    assign memory_enable    = (state == S_MEMORY);
    assign writeback_enable = (state == S_WRITEBACK);

endmodule

// File: src/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN           = 32;
    localparam int REG_ADDR_WIDTH = 5;

    localparam int ALU_OP_WIDTH = 3;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD    = 3'd0;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB    = 3'd1;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_AND    = 3'd2;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OR     = 3'd3;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR    = 3'd4;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SLT    = 3'd5;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_PASS_B = 3'd6;

    localparam int OPA_SEL_WIDTH = 1;
    localparam logic [OPA_SEL_WIDTH-1:0] OPA_RS1 = 1'b0;
    localparam logic [OPA_SEL_WIDTH-1:0] OPA_PC  = 1'b1;

    localparam int OPB_SEL_WIDTH = 2;
    localparam logic [OPB_SEL_WIDTH-1:0] OPB_RS2  = 2'd0;
    localparam logic [OPB_SEL_WIDTH-1:0] OPB_IMM  = 2'd1;
    localparam logic [OPB_SEL_WIDTH-1:0] OPB_FOUR = 2'd2;

    localparam int NEXT_PC_WIDTH = 2;
    localparam logic [NEXT_PC_WIDTH-1:0] NEXT_PC_SEQ        = 2'd0;
    localparam logic [NEXT_PC_WIDTH-1:0] NEXT_PC_IF_ZERO    = 2'd1;
    localparam logic [NEXT_PC_WIDTH-1:0] NEXT_PC_IF_NONZERO = 2'd2;
    localparam logic [NEXT_PC_WIDTH-1:0] NEXT_PC_ALWAYS     = 2'd3;

    localparam logic WB_SEL_ALU = 1'b0;
    localparam logic WB_SEL_RAM = 1'b1;

endpackage

// File: src/isa_pkg.sv
package isa_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // One instruction word, read through whichever format its opcode names
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    // custom-0
    localparam logic [6:0] OPC_OUT    = 7'b0001011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage
